// File: source/id_pkg.sv
package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  aluop_t;
    typedef logic [2:0]  alusel_t;

    // major opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // special function field, inst[5:0]
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_MOVZ = 6'b001010;
    localparam logic [5:0] FN_MOVN = 6'b001011;
    localparam logic [5:0] FN_MFHI = 6'b010000;
    localparam logic [5:0] FN_MTHI = 6'b010001;
    localparam logic [5:0] FN_MFLO = 6'b010010;
    localparam logic [5:0] FN_MTLO = 6'b010011;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    localparam aluop_t ALUOP_NOP   = 8'b00000000;
    localparam aluop_t ALUOP_SRL   = 8'b00000010;
    localparam aluop_t ALUOP_SRA   = 8'b00000011;
    localparam aluop_t ALUOP_JR    = 8'b00001000;
    localparam aluop_t ALUOP_JALR  = 8'b00001001;
    localparam aluop_t ALUOP_MOVZ  = 8'b00001010;
    localparam aluop_t ALUOP_MOVN  = 8'b00001011;
    localparam aluop_t ALUOP_MFHI  = 8'b00010000;
    localparam aluop_t ALUOP_MTHI  = 8'b00010001;
    localparam aluop_t ALUOP_MFLO  = 8'b00010010;
    localparam aluop_t ALUOP_MTLO  = 8'b00010011;
    localparam aluop_t ALUOP_ADD   = 8'b00100000;
    localparam aluop_t ALUOP_ADDU  = 8'b00100001;
    localparam aluop_t ALUOP_SUB   = 8'b00100010;
    localparam aluop_t ALUOP_SUBU  = 8'b00100011;
    localparam aluop_t ALUOP_AND   = 8'b00100100;
    localparam aluop_t ALUOP_OR    = 8'b00100101;
    localparam aluop_t ALUOP_XOR   = 8'b00100110;
    localparam aluop_t ALUOP_NOR   = 8'b00100111;
    localparam aluop_t ALUOP_SLT   = 8'b00101010;
    localparam aluop_t ALUOP_SLTU  = 8'b00101011;
    localparam aluop_t ALUOP_J     = 8'b01001111;
    localparam aluop_t ALUOP_JAL   = 8'b01010000;
    localparam aluop_t ALUOP_BEQ   = 8'b01010001;
    localparam aluop_t ALUOP_ADDI  = 8'b01010101;
    localparam aluop_t ALUOP_ADDIU = 8'b01010110;
    localparam aluop_t ALUOP_SLL   = 8'b01111100;

    localparam alusel_t ALUSEL_NOP   = 3'b000;
    localparam alusel_t ALUSEL_LOGIC = 3'b001;
    localparam alusel_t ALUSEL_SHIFT = 3'b010;
    localparam alusel_t ALUSEL_MOVE  = 3'b011;
    localparam alusel_t ALUSEL_ARITH = 3'b100;
    localparam alusel_t ALUSEL_JUMP  = 3'b110;

    localparam reg_addr_t NOP_REG  = 5'd0;
    localparam reg_addr_t LINK_REG = 5'd31;

    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        reg_addr_t wd;
        logic      wreg;
        logic      inst_valid;
    } dec_ctrl_t;

    typedef struct packed {
        logic  flag;
        word_t target;
        word_t link_addr;
        logic  next_in_delayslot;
    } branch_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
        word_t     link_addr;
        logic      in_delayslot;
        logic      inst_valid;
    } id_ex_t;

endpackage

// File: source/inst_decoder.sv
`timescale 1ns/10ps
module inst_decoder (
    input  logic              rst_n_i,
    input  id_pkg::inst_t     inst_i,
    input  id_pkg::word_t     reg2_i,
    output logic              reg1_read_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    output id_pkg::word_t     imm_o,
    output id_pkg::dec_ctrl_t ctrl_o
);
    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic [15:0]       imm16;
    id_pkg::reg_addr_t rs;
    id_pkg::reg_addr_t rt;
    id_pkg::reg_addr_t rd;
    id_pkg::reg_addr_t shamt;

    id_pkg::aluop_t    aluop;
    id_pkg::alusel_t   alusel;
    id_pkg::reg_addr_t wd;
    logic              wreg;
    logic              valid;
    logic              move_nz; // movn
    logic              move_z;  // movz

    function automatic id_pkg::aluop_t fn_aluop(input logic [5:0] fn);
        case (fn)
            id_pkg::FN_OR:   return id_pkg::ALUOP_OR;
            id_pkg::FN_AND:  return id_pkg::ALUOP_AND;
            id_pkg::FN_XOR:  return id_pkg::ALUOP_XOR;
            id_pkg::FN_NOR:  return id_pkg::ALUOP_NOR;
            id_pkg::FN_SLL:  return id_pkg::ALUOP_SLL;
            id_pkg::FN_SLLV: return id_pkg::ALUOP_SLL;
            id_pkg::FN_SRL:  return id_pkg::ALUOP_SRL;
            id_pkg::FN_SRLV: return id_pkg::ALUOP_SRL;
            id_pkg::FN_SRA:  return id_pkg::ALUOP_SRA;
            id_pkg::FN_SRAV: return id_pkg::ALUOP_SRA;
            id_pkg::FN_MFHI: return id_pkg::ALUOP_MFHI;
            id_pkg::FN_MFLO: return id_pkg::ALUOP_MFLO;
            id_pkg::FN_MTHI: return id_pkg::ALUOP_MTHI;
            id_pkg::FN_MTLO: return id_pkg::ALUOP_MTLO;
            id_pkg::FN_MOVN: return id_pkg::ALUOP_MOVN;
            id_pkg::FN_MOVZ: return id_pkg::ALUOP_MOVZ;
            id_pkg::FN_JR:   return id_pkg::ALUOP_JR;
            id_pkg::FN_JALR: return id_pkg::ALUOP_JALR;
            id_pkg::FN_SLT:  return id_pkg::ALUOP_SLT;
            id_pkg::FN_SLTU: return id_pkg::ALUOP_SLTU;
            id_pkg::FN_ADD:  return id_pkg::ALUOP_ADD;
            id_pkg::FN_ADDU: return id_pkg::ALUOP_ADDU;
            id_pkg::FN_SUB:  return id_pkg::ALUOP_SUB;
            id_pkg::FN_SUBU: return id_pkg::ALUOP_SUBU;
            default:         return id_pkg::ALUOP_NOP;
        endcase
    endfunction

    function automatic id_pkg::aluop_t op_aluop(input logic [5:0] op);
        case (op)
            id_pkg::OP_ORI:   return id_pkg::ALUOP_OR;
            id_pkg::OP_LUI:   return id_pkg::ALUOP_OR; // or with rs
            id_pkg::OP_ANDI:  return id_pkg::ALUOP_AND;
            id_pkg::OP_XORI:  return id_pkg::ALUOP_XOR;
            id_pkg::OP_SLTI:  return id_pkg::ALUOP_SLT;
            id_pkg::OP_SLTIU: return id_pkg::ALUOP_SLTU;
            id_pkg::OP_ADDI:  return id_pkg::ALUOP_ADDI;
            id_pkg::OP_ADDIU: return id_pkg::ALUOP_ADDIU;
            id_pkg::OP_J:     return id_pkg::ALUOP_J;
            id_pkg::OP_JAL:   return id_pkg::ALUOP_JAL;
            id_pkg::OP_BEQ:   return id_pkg::ALUOP_BEQ;
            default:          return id_pkg::ALUOP_NOP;
        endcase
    endfunction

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];

    always_comb begin
        aluop       = id_pkg::ALUOP_NOP;
        alusel      = id_pkg::ALUSEL_NOP;
        wd          = id_pkg::NOP_REG;
        wreg        = 1'b0;
        valid       = 1'b0;
        move_nz     = 1'b0;
        move_z      = 1'b0;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        reg1_addr_o = id_pkg::NOP_REG;
        reg2_addr_o = id_pkg::NOP_REG;
        imm_o       = '0;
        if (rst_n_i) begin
            wd          = rd;
            reg1_addr_o = rs;
            reg2_addr_o = rt;
            aluop       = (opcode == id_pkg::OP_SPECIAL) ? fn_aluop(funct) : op_aluop(opcode);
            case (opcode)
                id_pkg::OP_SPECIAL: begin
                    valid = (shamt == '0); // sa field must be clear
                    case (funct)
                        id_pkg::FN_OR, id_pkg::FN_AND, id_pkg::FN_XOR, id_pkg::FN_NOR: begin
                            alusel      = id_pkg::ALUSEL_LOGIC;
                            wreg        = 1'b1;
                            reg1_read_o = 1'b1;
                            reg2_read_o = 1'b1;
                        end
                        id_pkg::FN_SLLV, id_pkg::FN_SRLV, id_pkg::FN_SRAV: begin
                            alusel      = id_pkg::ALUSEL_SHIFT;
                            wreg        = 1'b1;
                            reg1_read_o = 1'b1;
                            reg2_read_o = 1'b1;
                        end
                        id_pkg::FN_SLT, id_pkg::FN_SLTU, id_pkg::FN_ADD,
                        id_pkg::FN_ADDU, id_pkg::FN_SUB, id_pkg::FN_SUBU: begin
                            alusel      = id_pkg::ALUSEL_ARITH;
                            wreg        = 1'b1;
                            reg1_read_o = 1'b1;
                            reg2_read_o = 1'b1;
                        end
                        id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA: begin
                            valid       = (rs == '0);
                            alusel      = id_pkg::ALUSEL_SHIFT;
                            wreg        = 1'b1;
                            reg2_read_o = 1'b1;
                            imm_o       = {27'b0, shamt}; // shift amount as operand 1
                        end
                        id_pkg::FN_MFHI, id_pkg::FN_MFLO: begin
                            alusel = id_pkg::ALUSEL_MOVE;
                            wreg   = 1'b1;
                        end
                        id_pkg::FN_MTHI, id_pkg::FN_MTLO: begin
                            alusel      = id_pkg::ALUSEL_MOVE;
                            reg1_read_o = 1'b1;
                        end
                        id_pkg::FN_MOVN, id_pkg::FN_MOVZ: begin
                            alusel      = id_pkg::ALUSEL_MOVE;
                            reg1_read_o = 1'b1;
                            reg2_read_o = 1'b1;
                            move_nz     = (funct == id_pkg::FN_MOVN);
                            move_z      = (funct == id_pkg::FN_MOVZ);
                        end
                        id_pkg::FN_JR, id_pkg::FN_JALR: begin
                            alusel      = id_pkg::ALUSEL_JUMP;
                            wreg        = (funct == id_pkg::FN_JALR); // link into rd
                            reg1_read_o = 1'b1;
                        end
                        default: valid = 1'b0;
                    endcase
                end
                id_pkg::OP_ORI, id_pkg::OP_ANDI, id_pkg::OP_XORI, id_pkg::OP_LUI: begin
                    valid       = 1'b1;
                    alusel      = id_pkg::ALUSEL_LOGIC;
                    wreg        = 1'b1;
                    wd          = rt;
                    reg1_read_o = 1'b1;
                    imm_o       = (opcode == id_pkg::OP_LUI) ? {imm16, 16'h0} : {16'h0, imm16};
                end
                id_pkg::OP_SLTI, id_pkg::OP_SLTIU, id_pkg::OP_ADDI, id_pkg::OP_ADDIU: begin
                    valid       = 1'b1;
                    alusel      = id_pkg::ALUSEL_ARITH;
                    wreg        = 1'b1;
                    wd          = rt;
                    reg1_read_o = 1'b1;
                    imm_o       = {{16{imm16[15]}}, imm16};
                end
                id_pkg::OP_J, id_pkg::OP_JAL: begin
                    valid  = 1'b1;
                    alusel = id_pkg::ALUSEL_JUMP;
                    wreg   = (opcode == id_pkg::OP_JAL);
                    wd     = id_pkg::LINK_REG; // only written for jal
                end
                id_pkg::OP_BEQ: begin
                    valid       = 1'b1;
                    alusel      = id_pkg::ALUSEL_JUMP;
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                end
                default: valid = 1'b0;
            endcase
        end
        if (!valid) begin
            aluop       = id_pkg::ALUOP_NOP;
            alusel      = id_pkg::ALUSEL_NOP;
            wreg        = 1'b0;
            move_nz     = 1'b0;
            move_z      = 1'b0;
            reg1_read_o = 1'b0;
            reg2_read_o = 1'b0;
            imm_o       = '0;
        end
    end

    // conditional moves decided from the forwarded operand 2
    assign ctrl_o.aluop      = aluop;
    assign ctrl_o.alusel     = alusel;
    assign ctrl_o.wd         = wd;
    assign ctrl_o.wreg       = wreg | (move_nz & (reg2_i != '0)) | (move_z & (reg2_i == '0));
    assign ctrl_o.inst_valid = valid;

endmodule

// File: source/operand_mux.sv
`timescale 1ns/10ps
module operand_mux (
    input  logic              read_i,
    input  id_pkg::reg_addr_t addr_i,
    input  id_pkg::word_t     reg_data_i,
    input  id_pkg::word_t     imm_i,
    input  id_pkg::fwd_t      ex_fwd_i,
    input  id_pkg::fwd_t      mem_fwd_i,
    output id_pkg::word_t     operand_o
);
    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = read_i && ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
    assign mem_hit = read_i && mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

    always_comb begin
        if (ex_hit) begin
            operand_o = ex_fwd_i.wdata;  // newest result wins
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else if (read_i) begin
            operand_o = reg_data_i;
        end else begin
            operand_o = imm_i;
        end
    end

endmodule

// File: source/branch_resolver.sv
`timescale 1ns/10ps
module branch_resolver (
    input  logic            rst_n_i,
    input  id_pkg::inst_t   inst_i,
    input  id_pkg::word_t   pc_i,
    input  id_pkg::word_t   reg1_i,
    input  id_pkg::word_t   reg2_i,
    output id_pkg::branch_t branch_o
);
    logic [5:0]    opcode;
    logic [5:0]    funct;
    logic          jump_reg;
    id_pkg::word_t pc_plus_4;
    id_pkg::word_t pc_plus_8;
    id_pkg::word_t jump_target;
    id_pkg::word_t beq_offset;

    assign opcode      = inst_i[31:26];
    assign funct       = inst_i[5:0];
    assign pc_plus_4   = pc_i + 32'd4;
    assign pc_plus_8   = pc_i + 32'd8;  // past the delay slot
    assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
    assign beq_offset  = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign jump_reg    = (opcode == id_pkg::OP_SPECIAL) && (inst_i[10:6] == '0) &&
                         ((funct == id_pkg::FN_JR) || (funct == id_pkg::FN_JALR));

    always_comb begin
        branch_o = '0;
        if (rst_n_i) begin
            if (opcode == id_pkg::OP_J || opcode == id_pkg::OP_JAL) begin
                branch_o.flag   = 1'b1;
                branch_o.target = jump_target;
                if (opcode == id_pkg::OP_JAL) begin
                    branch_o.link_addr = pc_plus_8;
                end
            end else if (jump_reg) begin
                branch_o.flag   = 1'b1;
                branch_o.target = reg1_i;
                if (funct == id_pkg::FN_JALR) begin
                    branch_o.link_addr = pc_plus_8;
                end
            end else if (opcode == id_pkg::OP_BEQ && reg1_i == reg2_i) begin
                branch_o.flag   = 1'b1;
                branch_o.target = pc_plus_4 + beq_offset;
            end
            branch_o.next_in_delayslot = branch_o.flag;
        end
    end

endmodule

// File: source/id_ex_reg.sv
`timescale 1ns/10ps
module id_ex_reg (
    input  logic           clk,
    input  logic           rst_n_i,
    input  id_pkg::id_ex_t d_i,
    output id_pkg::id_ex_t q_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;  // bubble into execute
        end else begin
            q_o <= d_i;
        end
    end

endmodule

// File: source/id_stage.sv
`timescale 1ns/10ps
module id_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  id_pkg::word_t     pc_i,
    input  id_pkg::inst_t     inst_i,
    input  id_pkg::word_t     reg1_data_i,
    input  id_pkg::word_t     reg2_data_i,
    input  id_pkg::fwd_t      ex_fwd_i,
    input  id_pkg::fwd_t      mem_fwd_i,
    input  logic              is_in_delayslot_i,
    output logic              reg1_read_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    output id_pkg::branch_t   branch_o,
    output id_pkg::id_ex_t    id_ex_o
);
    id_pkg::dec_ctrl_t ctrl;
    id_pkg::word_t     imm;
    id_pkg::word_t     reg1;
    id_pkg::word_t     reg2;
    id_pkg::id_ex_t    id_ex_d;

    inst_decoder u_dec (
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .reg2_i      (reg2),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .imm_o       (imm),
        .ctrl_o      (ctrl)
    );

    operand_mux u_op1 (
        .read_i     (reg1_read_o),
        .addr_i     (reg1_addr_o),
        .reg_data_i (reg1_data_i),
        .imm_i      (imm),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .operand_o  (reg1)
    );

    operand_mux u_op2 (
        .read_i     (reg2_read_o),
        .addr_i     (reg2_addr_o),
        .reg_data_i (reg2_data_i),
        .imm_i      (imm),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .operand_o  (reg2)
    );

    branch_resolver u_branch (
        .rst_n_i  (rst_n_i),
        .inst_i   (inst_i),
        .pc_i     (pc_i),
        .reg1_i   (reg1),
        .reg2_i   (reg2),
        .branch_o (branch_o)
    );

    assign id_ex_d = '{
        aluop:        ctrl.aluop,
        alusel:       ctrl.alusel,
        reg1:         reg1,
        reg2:         reg2,
        wd:           ctrl.wd,
        wreg:         ctrl.wreg,
        link_addr:    branch_o.link_addr,
        in_delayslot: is_in_delayslot_i,
        inst_valid:   ctrl.inst_valid
    };

    id_ex_reg u_id_ex (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .d_i     (id_ex_d),
        .q_o     (id_ex_o)
    );

endmodule

// File: testbench/tb_id_stage.sv
`timescale 1ns/10ps
module tb_id_stage;
    logic              clk;
    logic              rst_n_i;
    id_pkg::word_t     pc_i;
    id_pkg::inst_t     inst_i;
    id_pkg::word_t     reg1_data_i;
    id_pkg::word_t     reg2_data_i;
    id_pkg::fwd_t      ex_fwd_i;
    id_pkg::fwd_t      mem_fwd_i;
    logic              is_in_delayslot_i;
    logic              reg1_read_o;
    logic              reg2_read_o;
    id_pkg::reg_addr_t reg1_addr_o;
    id_pkg::reg_addr_t reg2_addr_o;
    id_pkg::branch_t   branch_o;
    id_pkg::id_ex_t    id_ex_o;

    int                fd;
    int                case_no;
    string             line;
    id_pkg::word_t     c_pc;
    id_pkg::inst_t     c_inst;
    logic [37:0]       c_ex;
    logic [37:0]       c_mem;
    logic [1:0]        c_flags;   // bit0 delay slot, bit1 random data on unread ports
    logic [1:0]        c_rden;
    logic              c_flag;
    id_pkg::word_t     c_target;
    id_pkg::word_t     c_link;
    id_pkg::aluop_t    c_aluop;
    id_pkg::alusel_t   c_alusel;
    id_pkg::word_t     c_op1;
    id_pkg::word_t     c_op2;
    id_pkg::reg_addr_t c_wd;
    logic              c_wreg;
    logic              c_valid;

    id_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // register file model, every register holds its number in each byte
    function automatic id_pkg::word_t regfile_value(input id_pkg::reg_addr_t r);
        return {4{3'b000, r}};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s (at %0d ns)", reason, $time);
        $display("*** FAILED ***");
        $fatal(1, "%s", reason);
    endtask

    task automatic wait_edge(input logic level);
        int events;
        events = 0;
        do begin
            @(clk);
            events++;
        end while (clk !== level && events < 4);
        if (clk !== level) begin
            abort_run("timeout while waiting for a clock edge");
        end
    endtask

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("FAIL at %0d ns: case %0d, %s is %0h, expected %0h",
                     $time, case_no, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_quiet(input logic in_reset);
        check_value("id_ex_o", 128'(id_ex_o), 128'd0);
        check_value("branch_o", 128'(branch_o), 128'd0);
        check_value("reg1_read_o", 128'(reg1_read_o), 128'd0);
        check_value("reg2_read_o", 128'(reg2_read_o), 128'd0);
        if (in_reset) begin
            check_value("reg1_addr_o", 128'(reg1_addr_o), 128'd0);
            check_value("reg2_addr_o", 128'(reg2_addr_o), 128'd0);
        end
    endtask

    task automatic run_case();
        wait_edge(1'b0);
        pc_i              = c_pc;
        inst_i            = c_inst;
        ex_fwd_i          = c_ex;
        mem_fwd_i         = c_mem;
        is_in_delayslot_i = c_flags[0];
        reg1_data_i       = regfile_value(c_inst[25:21]);
        reg2_data_i       = regfile_value(c_inst[20:16]);
        if (c_flags[1] && !c_rden[1]) begin
            reg1_data_i = $urandom;
        end
        if (c_flags[1] && !c_rden[0]) begin
            reg2_data_i = $urandom;
        end
        #8;  // just before the rising edge
        check_value("reg1_read_o", 128'(reg1_read_o), 128'(c_rden[1]));
        check_value("reg2_read_o", 128'(reg2_read_o), 128'(c_rden[0]));
        check_value("reg1_addr_o", 128'(reg1_addr_o), 128'(c_inst[25:21]));
        check_value("reg2_addr_o", 128'(reg2_addr_o), 128'(c_inst[20:16]));
        check_value("branch flag", 128'(branch_o.flag), 128'(c_flag));
        check_value("branch target", 128'(branch_o.target), 128'(c_target));
        check_value("branch link", 128'(branch_o.link_addr), 128'(c_link));
        check_value("next in delay slot", 128'(branch_o.next_in_delayslot), 128'(c_flag));
        wait_edge(1'b1);
        #1;
        check_value("aluop", 128'(id_ex_o.aluop), 128'(c_aluop));
        check_value("alusel", 128'(id_ex_o.alusel), 128'(c_alusel));
        check_value("reg1", 128'(id_ex_o.reg1), 128'(c_op1));
        check_value("reg2", 128'(id_ex_o.reg2), 128'(c_op2));
        check_value("wd", 128'(id_ex_o.wd), 128'(c_wd));
        check_value("wreg", 128'(id_ex_o.wreg), 128'(c_wreg));
        check_value("link_addr", 128'(id_ex_o.link_addr), 128'(c_link));
        check_value("in_delayslot", 128'(id_ex_o.in_delayslot), 128'(c_flags[0]));
        check_value("inst_valid", 128'(id_ex_o.inst_valid), 128'(c_valid));
    endtask

    initial begin
        void'($urandom(3026));
        rst_n_i           = 1'b0;
        pc_i              = 32'h0040_0040;
        inst_i            = 32'h1022_0004;  // beq reading rs and rt, must stay hidden by reset
        reg1_data_i       = $urandom;
        reg2_data_i       = reg1_data_i;    // equal operands, taken if not held
        ex_fwd_i          = '0;
        mem_fwd_i         = '0;
        is_in_delayslot_i = 1'b1;
        case_no           = 0;
        fd = $fopen("testbench/id_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open testbench/id_cases.txt");
        end
        repeat (2) wait_edge(1'b1);
        #1;
        check_quiet(1'b1);
        wait_edge(1'b1);
        wait_edge(1'b0);
        rst_n_i           = 1'b1;
        inst_i            = 32'hfc00_0000;  // undefined opcode, all fields zero
        is_in_delayslot_i = 1'b0;
        wait_edge(1'b1);
        #1;
        check_quiet(1'b0);
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        c_pc, c_inst, c_ex, c_mem, c_flags, c_rden, c_flag, c_target,
                        c_link, c_aluop, c_alusel, c_op1, c_op2, c_wd, c_wreg,
                        c_valid) != 16) begin
                abort_run("malformed line in testbench/id_cases.txt");
            end
            case_no++;
            run_case();
        end
        $fclose(fd);
        if (case_no > 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("no cases found in testbench/id_cases.txt");
        end
    end

endmodule

// File: testbench/id_cases.txt
# pc inst ex_fwd mem_fwd flags rd_en br_flag br_target link aluop alusel op1 op2 wd wreg valid
# fwd = {wreg, wd, wdata}; flags bit0 delay slot, bit1 random unread data; rd_en bit1 rs, bit0 rt
00400000 34238001 0000000000 0000000000 0 2 0 00000000 00000000 25 1 01010101 00008001 03 1 1
00400004 3044ff00 0000000000 0000000000 0 2 0 00000000 00000000 24 1 02020202 0000ff00 04 1 1
00400008 2025fffc 0000000000 0000000000 0 2 0 00000000 00000000 55 4 01010101 fffffffc 05 1 1
0040000c 28468000 0000000000 0000000000 0 2 0 00000000 00000000 2a 4 02020202 ffff8000 06 1 1
00400010 3c071234 0000000000 0000000000 0 2 0 00000000 00000000 25 1 00000000 12340000 07 1 1
00400014 00034140 0000000000 0000000000 2 1 0 00000000 00000000 7c 2 00000005 03030303 08 1 1
00400018 00224825 21aaaa0001 21bbbb0001 0 3 0 00000000 00000000 25 1 aaaa0001 02020202 09 1 1
0040001c 00224825 23aaaa0003 21bbbb0001 0 3 0 00000000 00000000 25 1 bbbb0001 02020202 09 1 1
00400020 00224825 01aaaa0001 0000000000 0 3 0 00000000 00000000 25 1 01010101 02020202 09 1 1
00400024 0022500b 0000000000 0000000000 0 3 0 00000000 00000000 0b 3 01010101 02020202 0a 1 1
00400028 0022500b 2200000000 0000000000 0 3 0 00000000 00000000 0b 3 01010101 00000000 0a 0 1
0040002c 0022580a 0000000000 2200000000 0 3 0 00000000 00000000 0a 3 01010101 00000000 0b 1 1
30000100 08123456 0000000000 0000000000 2 0 1 3048d158 00000000 4f 6 00000000 00000000 1f 0 1
00400040 0c100040 0000000000 0000000000 3 0 1 00400100 00400048 50 6 00000000 00000000 1f 1 1
00400100 00200008 2100400100 0000000000 2 2 1 00400100 00000000 08 6 00400100 00000000 00 0 1
00400200 0040f809 0000000000 0000000000 2 2 1 02020202 00400208 09 6 02020202 00000000 1f 1 1
00400300 1021fffe 0000000000 0000000000 0 3 1 004002fc 00000000 51 6 01010101 01010101 1f 0 1
00400304 10220010 0000000000 0000000000 1 3 0 00000000 00000000 51 6 01010101 02020202 00 0 1
00400308 00220018 0000000000 0000000000 2 0 0 00000000 00000000 00 0 00000000 00000000 00 0 0
0040030c 70231820 0000000000 0000000000 2 0 0 00000000 00000000 00 0 00000000 00000000 03 0 0
00400310 0000000f 0000000000 0000000000 2 0 0 00000000 00000000 00 0 00000000 00000000 00 0 0

// File: mips_id.f
source/id_pkg.sv
source/inst_decoder.sv
source/operand_mux.sv
source/branch_resolver.sv
source/id_ex_reg.sv
source/id_stage.sv
testbench/tb_id_stage.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_id_stage
FILELIST := mips_id.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
